// File: lsu_defines.svh
/* Shared constants of the RV32 load/store unit.
   Include wherever widths, opcodes, funct3 codes or AHB size codes are needed. */

`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// ==============================
// Data path
// ==============================
`define LSU_XLEN 32

// ==============================
// RV32 opcodes
// ==============================
`define LSU_OPC_LOAD  7'b0000011
`define LSU_OPC_STORE 7'b0100011

// ==============================
// funct3 codes
// ==============================
// Loads
`define LSU_F3_LB  3'b000
`define LSU_F3_LH  3'b001
`define LSU_F3_LW  3'b010
`define LSU_F3_LBU 3'b100
`define LSU_F3_LHU 3'b101

// Stores
`define LSU_F3_SB  3'b000
`define LSU_F3_SH  3'b001
`define LSU_F3_SW  3'b010

// AHB transfer size codes
`define LSU_HSIZE_BYTE 3'b000
`define LSU_HSIZE_HALF 3'b001
`define LSU_HSIZE_WORD 3'b010

`endif

// File: lsu_pkg.sv
/* Types of the load/store unit: instruction formats, request and data-phase state.
   Modules import it inside their body and use scoped names in their port lists. */

`include "lsu_defines.svh"

package lsu_pkg;

   // I-type view, used by loads
   typedef struct packed {
      logic [11:0] imm12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } i_fmt_t;

   // S-type view, used by stores
   typedef struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
   } s_fmt_t;

   // Same word, two decodings
   typedef union packed {
      i_fmt_t i;
      s_fmt_t s;
   } inst_word_t;

   // Encoded like the AHB size so it maps straight through
   typedef enum logic [1:0] {
      MEM_BYTE = 2'd0,
      MEM_HALF = 2'd1,
      MEM_WORD = 2'd2
   } mem_size_t;

   typedef struct packed {
      logic                 valid;
      logic                 write;
      logic                 unsigned_ld;
      mem_size_t            size;
      logic [`LSU_XLEN-1:0] addr;
      logic [4:0]           rd;
      logic [`LSU_XLEN-1:0] store_data;
   } mem_req_t;

   // State kept while a transfer sits in its data phase
   typedef struct packed {
      logic      active;
      logic      write;
      logic      unsigned_ld;
      mem_size_t size;
      logic [1:0] offset;
      logic [4:0] rd;
   } dphase_t;

endpackage

// File: lsu_decode.sv
/* Combinational decode of one load or store word into a memory request.
   Rebuilds the immediate, forms the byte address and flags illegal words. */

`timescale 1ns/1ps
`include "lsu_defines.svh"

module lsu_decode (
   input  lsu_pkg::inst_word_t  inst,
   input  logic                 inst_valid,
   input  logic [`LSU_XLEN-1:0] rs1_value,
   input  logic [`LSU_XLEN-1:0] rs2_value,
   output lsu_pkg::mem_req_t    req,
   output logic                 illegal_instruction
);
   import lsu_pkg::*;

   logic                 is_load;
   logic                 is_store;
   logic                 f3_ok;
   logic                 misaligned;
   logic                 legal;
   logic                 unsigned_ld;
   mem_size_t            size;
   logic [`LSU_XLEN-1:0] imm_sext;
   logic [`LSU_XLEN-1:0] addr;

   assign is_load  = (inst.i.opcode == `LSU_OPC_LOAD);
   assign is_store = (inst.s.opcode == `LSU_OPC_STORE);

   // ==============================
   // Immediate and address
   // ==============================
   always_comb begin
      if (is_store) begin
         imm_sext = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
      end else begin
         imm_sext = {{20{inst.i.imm12[11]}}, inst.i.imm12};
      end
   end

   assign addr = rs1_value + imm_sext;

   // ==============================
   // funct3 to size and signedness
   // ==============================
   always_comb begin
      size        = MEM_WORD;
      unsigned_ld = 1'b0;
      f3_ok       = 1'b0;
      if (is_load) begin
         case (inst.i.funct3)
            `LSU_F3_LB: begin
               size  = MEM_BYTE;
               f3_ok = 1'b1;
            end
            `LSU_F3_LH: begin
               size  = MEM_HALF;
               f3_ok = 1'b1;
            end
            `LSU_F3_LW: begin
               size  = MEM_WORD;
               f3_ok = 1'b1;
            end
            `LSU_F3_LBU: begin
               size        = MEM_BYTE;
               unsigned_ld = 1'b1;
               f3_ok       = 1'b1;
            end
            `LSU_F3_LHU: begin
               size        = MEM_HALF;
               unsigned_ld = 1'b1;
               f3_ok       = 1'b1;
            end
            default: f3_ok = 1'b0;
         endcase
      end else if (is_store) begin
         case (inst.s.funct3)
            `LSU_F3_SB: begin
               size  = MEM_BYTE;
               f3_ok = 1'b1;
            end
            `LSU_F3_SH: begin
               size  = MEM_HALF;
               f3_ok = 1'b1;
            end
            `LSU_F3_SW: begin
               size  = MEM_WORD;
               f3_ok = 1'b1;
            end
            default: f3_ok = 1'b0;
         endcase
      end
   end

   // Half needs bit 0 clear, word needs both low bits clear
   always_comb begin
      case (size)
         MEM_HALF: misaligned = addr[0];
         MEM_WORD: misaligned = |addr[1:0];
         default:  misaligned = 1'b0;
      endcase
   end

   // f3_ok is only ever set for a load or store opcode
   assign legal = f3_ok & ~misaligned;

   always_comb begin
      req.valid       = inst_valid & legal;
      req.write       = is_store;
      req.unsigned_ld = unsigned_ld;
      req.size        = size;
      req.addr        = addr;
      // rd bits of an S-type word hold imm_lo
      req.rd          = is_load ? inst.i.rd : 5'd0;
      req.store_data  = rs2_value;
   end

   assign illegal_instruction = inst_valid & ~legal;

endmodule

// File: lsu_store_align.sv
/* Moves store data onto the byte lanes chosen by the address offset and
   derives the AHB transfer size for reads and writes alike. */

`timescale 1ns/1ps
`include "lsu_defines.svh"

module lsu_store_align (
   input  lsu_pkg::mem_req_t    req,
   output logic [`LSU_XLEN-1:0] wdata,
   output logic [2:0]           hsized
);
   import lsu_pkg::*;

   // ==============================
   // Lane placement
   // ==============================
   // Unused lanes stay zero
   always_comb begin
      case (req.size)
         MEM_BYTE: begin
            wdata = {24'b0, req.store_data[7:0]} << {req.addr[1:0], 3'b000};
         end
         MEM_HALF: begin
            wdata = {16'b0, req.store_data[15:0]} << {req.addr[1], 4'b0000};
         end
         default: begin
            wdata = req.store_data;
         end
      endcase
   end

   // ==============================
   // Transfer size
   // ==============================
   always_comb begin
      case (req.size)
         MEM_BYTE: hsized = `LSU_HSIZE_BYTE;
         MEM_HALF: hsized = `LSU_HSIZE_HALF;
         default:  hsized = `LSU_HSIZE_WORD;
      endcase
   end

endmodule

// File: lsu_load_align.sv
/* Picks the loaded byte or halfword out of the read word and extends it.
   Driven by the offset and size captured for the data phase. */

`timescale 1ns/1ps
`include "lsu_defines.svh"

module lsu_load_align (
   input  lsu_pkg::dphase_t     dphase,
   input  logic [`LSU_XLEN-1:0] hrdatad,
   output logic [`LSU_XLEN-1:0] load_value
);
   import lsu_pkg::*;

   logic [7:0]  byte_sel;
   logic [15:0] half_sel;
   logic        byte_fill;
   logic        half_fill;

   // Lane select from the captured offset
   assign byte_sel = hrdatad[{dphase.offset, 3'b000} +: 8];
   assign half_sel = hrdatad[{dphase.offset[1], 4'b0000} +: 16];

   // Sign bit, or zero for LBU/LHU
   assign byte_fill = byte_sel[7] & ~dphase.unsigned_ld;
   assign half_fill = half_sel[15] & ~dphase.unsigned_ld;

   always_comb begin
      case (dphase.size)
         MEM_BYTE: load_value = {{24{byte_fill}}, byte_sel};
         MEM_HALF: load_value = {{16{half_fill}}, half_sel};
         default:  load_value = hrdatad;
      endcase
   end

endmodule

// File: lsu_phase_ctrl.sv
/* Address/data phase tracking of the data port: registers write data and
   data-phase state on acceptance, and produces stall and register write-back. */

`timescale 1ns/1ps
`include "lsu_defines.svh"

module lsu_phase_ctrl (
   input  logic                 clk,
   input  logic                 rst_n,
   input  lsu_pkg::mem_req_t    req,
   input  logic [`LSU_XLEN-1:0] wdata,
   input  logic                 hreadyd,
   input  logic [`LSU_XLEN-1:0] load_value,
   output lsu_pkg::dphase_t     dphase,
   output logic [`LSU_XLEN-1:0] hwdatad,
   output logic                 htransd,
   output logic                 stall,
   output logic                 wb_valid,
   output logic [4:0]           wb_rd,
   output logic [`LSU_XLEN-1:0] wb_data
);
   import lsu_pkg::*;

   dphase_t              dphase_q;
   logic [`LSU_XLEN-1:0] wdata_q;

   // ==============================
   // Address phase
   // ==============================
   // Not gated by stall so the next address phase overlaps the data phase
   assign htransd = req.valid;

   // ==============================
   // Data-phase registers
   // ==============================
   // hreadyd high ends the current data phase and accepts the next request
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         dphase_q <= '0;
         wdata_q  <= '0;
      end else if (hreadyd) begin
         dphase_q.active      <= req.valid;
         dphase_q.write       <= req.write;
         dphase_q.unsigned_ld <= req.unsigned_ld;
         dphase_q.size        <= req.size;
         dphase_q.offset      <= req.addr[1:0];
         dphase_q.rd          <= req.rd;
         if (req.valid) begin
            wdata_q <= wdata;
         end
      end
   end

   assign dphase  = dphase_q;
   assign hwdatad = wdata_q;

   // ==============================
   // Stall and write-back
   // ==============================
   assign stall = dphase_q.active & ~hreadyd;

   // Loads only, and never to x0
   assign wb_valid = dphase_q.active & ~dphase_q.write & hreadyd & (|dphase_q.rd);
   assign wb_rd    = dphase_q.rd;
   assign wb_data  = load_value;

endmodule

// File: lsu_top.sv
/* Top level of the RV32 load/store unit: core side on one end, AHB-lite
   data port on the other. Wiring only, the work lives in the four sub-blocks. */

`timescale 1ns/1ps
`include "lsu_defines.svh"

module lsu_top (
   input  logic                 clk,
   input  logic                 rst_n,
   // Core side
   input  logic                 inst_valid,
   input  logic [31:0]          inst,
   input  logic [`LSU_XLEN-1:0] rs1_value,
   input  logic [`LSU_XLEN-1:0] rs2_value,
   output logic                 stall,
   output logic                 illegal_instruction,
   output logic                 wb_valid,
   output logic [4:0]           wb_rd,
   output logic [`LSU_XLEN-1:0] wb_data,
   // AHB-lite data port
   input  logic [`LSU_XLEN-1:0] hrdatad,
   input  logic                 hreadyd,
   output logic [`LSU_XLEN-1:0] haddrd,
   output logic                 htransd,
   output logic                 hwrited,
   output logic [2:0]           hsized,
   output logic [`LSU_XLEN-1:0] hwdatad
);
   import lsu_pkg::*;

   mem_req_t             req;
   dphase_t              dphase;
   logic [`LSU_XLEN-1:0] wdata;
   logic [`LSU_XLEN-1:0] load_value;

   lsu_decode u_decode (
      .inst                (inst),
      .inst_valid          (inst_valid),
      .rs1_value           (rs1_value),
      .rs2_value           (rs2_value),
      .req                 (req),
      .illegal_instruction (illegal_instruction)
   );

   lsu_store_align u_store_align (
      .req    (req),
      .wdata  (wdata),
      .hsized (hsized)
   );

   lsu_load_align u_load_align (
      .dphase     (dphase),
      .hrdatad    (hrdatad),
      .load_value (load_value)
   );

   lsu_phase_ctrl u_phase_ctrl (
      .clk        (clk),
      .rst_n      (rst_n),
      .req        (req),
      .wdata      (wdata),
      .hreadyd    (hreadyd),
      .load_value (load_value),
      .dphase     (dphase),
      .hwdatad    (hwdatad),
      .htransd    (htransd),
      .stall      (stall),
      .wb_valid   (wb_valid),
      .wb_rd      (wb_rd),
      .wb_data    (wb_data)
   );

   // Address phase straight from the decoded request
   assign haddrd  = req.addr;
   assign hwrited = req.write;

endmodule

// File: lsu_chk.sv
/* Bus protocol and control-output assertions for the load/store unit.
   Bound into every lsu_top instance. */

`timescale 1ns/1ps

module lsu_chk (
   input logic clk,
   input logic rst_n,
   input logic hreadyd,
   input logic htransd,
   input logic hwrited,
   input logic stall,
   input logic wb_valid,
   input logic illegal_instruction
);

   int unsigned fail_count = 0;

   logic dp_active;
   logic dp_write;

   // Data phase as seen on the bus
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         dp_active <= 1'b0;
         dp_write  <= 1'b0;
      end else if (hreadyd) begin
         dp_active <= htransd;
         dp_write  <= hwrited;
      end
   end

   // Stall only comes from slave wait states
   assert property (@(posedge clk) disable iff (!rst_n)
                    stall |-> (!hreadyd && dp_active)) else begin
      fail_count++;
      $error("stall high without a data phase waiting on hreadyd");
   end

   // Stores never write back
   assert property (@(posedge clk) disable iff (!rst_n)
                    wb_valid |-> (dp_active && !dp_write && hreadyd)) else begin
      fail_count++;
      $error("wb_valid outside a completing load data phase");
   end

   assert property (@(posedge clk) disable iff (!rst_n)
                    !(htransd && illegal_instruction)) else begin
      fail_count++;
      $error("transfer issued for an illegal instruction");
   end

endmodule

bind lsu_top lsu_chk u_chk (
   .clk                 (clk),
   .rst_n               (rst_n),
   .hreadyd             (hreadyd),
   .htransd             (htransd),
   .hwrited             (hwrited),
   .stall               (stall),
   .wb_valid            (wb_valid),
   .illegal_instruction (illegal_instruction)
);

// File: tb_lsu.sv
/* Self-checking testbench for the load/store unit. Runs directed and random loads and
   stores against an AHB-lite memory slave with wait states and a reference model. */

`timescale 1ns/1ps
`include "lsu_defines.svh"

module tb_lsu;

   localparam int          N_DIRECTED  = 27;
   localparam int          N_RANDOM    = 400;
   localparam int          CYCLE_LIMIT = 4 * (N_DIRECTED + N_RANDOM) + 200;
   localparam logic [31:0] DIR_BASE    = 32'h0000_0040;

   // One expected completion per accepted transfer
   typedef struct packed {
      logic        wb;
      logic [4:0]  rd;
      logic [31:0] data;
   } exp_t;

   logic        clk = 1'b0;
   logic        rst_n;
   logic        inst_valid;
   logic [31:0] inst;
   logic [31:0] rs1_value;
   logic [31:0] rs2_value;
   logic [31:0] hrdatad = 32'd0;
   logic        hreadyd = 1'b1;
   logic [31:0] haddrd;
   logic        htransd;
   logic        hwrited;
   logic [2:0]  hsized;
   logic [31:0] hwdatad;
   logic        stall;
   logic        illegal_instruction;
   logic        wb_valid;
   logic [4:0]  wb_rd;
   logic [31:0] wb_data;

   integer      seed = 14;
   int          errors = 0;
   int          checks = 0;
   int          cycles = 0;
   exp_t        exp_q[$];
   logic [31:0] mem [0:63];
   logic [31:0] model_mem [0:63];

   // Slave data-phase state
   logic        pending = 1'b0;
   logic        d_write;
   logic [5:0]  d_idx;
   logic [3:0]  d_lanes;
   logic [31:0] bus_r;

   always #5 clk = ~clk;

   lsu_top UUT (.*);

   // ==============================
   // Reference model
   // ==============================
   function automatic logic [31:0] fill_word(input int idx);
      return 32'h9E37_79B9 * (idx + 1);
   endfunction

   function automatic logic is_legal(input logic store, input logic [2:0] f3,
                                     input logic [1:0] off, input logic bad_opc);
      logic f3_ok;
      f3_ok = store ? (f3 <= 3'b010) : (f3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101});
      return !bad_opc && f3_ok && !(f3[1:0] == 2'd1 && off[0])
             && !(f3[1:0] == 2'd2 && off != 2'd0);
   endfunction

   // Memory word after a store of size f3 at byte offset off
   function automatic logic [31:0] merge_store(input logic [31:0] old, input logic [2:0] f3,
                                               input logic [1:0] off, input logic [31:0] data);
      logic [31:0] res;
      res = old;
      case (f3[1:0])
         2'd0:    res[8*off +: 8] = data[7:0];
         2'd1:    res[16*off[1] +: 16] = data[15:0];
         default: res = data;
      endcase
      return res;
   endfunction

   function automatic logic [31:0] load_result(input logic [31:0] word, input logic [2:0] f3,
                                               input logic [1:0] off);
      logic [7:0]  b;
      logic [15:0] h;
      b = word[8*off +: 8];
      h = word[16*off[1] +: 16];
      case (f3)
         `LSU_F3_LB:  return {{24{b[7]}}, b};
         `LSU_F3_LBU: return {24'd0, b};
         `LSU_F3_LH:  return {{16{h[15]}}, h};
         `LSU_F3_LHU: return {16'd0, h};
         default:     return word;
      endcase
   endfunction

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      checks++;
      assert (actual === expected) else begin
         errors++;
         $display("[FAIL] %0t %s expected %h got %h", $time, name, expected, actual);
      end
   endtask

   task automatic finish_run();
      $display("Checks: %0d, errors: %0d, assertion failures: %0d",
               checks, errors, UUT.u_chk.fail_count);
      if (errors == 0 && UUT.u_chk.fail_count == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   endtask

   // Presents one word and holds it until the unit takes it
   task automatic apply_op(input logic store, input logic [2:0] f3, input logic [31:0] addr,
                           input logic [4:0] rd, input logic [31:0] data,
                           input logic bad_opc);
      logic [31:0] r;
      logic [11:0] imm;
      logic [6:0]  opc;
      logic        legal;
      logic        busy;
      exp_t        e;
      r     = $random(seed);
      imm   = r[11:0];
      opc   = bad_opc ? 7'b0010011 : (store ? `LSU_OPC_STORE : `LSU_OPC_LOAD);
      legal = is_legal(store, f3, addr[1:0], bad_opc);
      #1;
      inst_valid = 1'b1;
      rs1_value  = addr - {{20{imm[11]}}, imm};
      rs2_value  = data;
      inst = store ? {imm[11:5], r[16:12], r[21:17], f3, imm[4:0], opc}
                   : {imm, r[21:17], f3, rd, opc};
      do begin
         @(posedge clk);
         check_value("htransd", 32'(legal), 32'(htransd));
         check_value("illegal_instruction", 32'(!legal), 32'(illegal_instruction));
         if (legal) begin
            check_value("haddrd", addr, haddrd);
            check_value("hwrited", 32'(store), 32'(hwrited));
            check_value("hsized", 32'(f3[1:0]), 32'(hsized));
         end
         busy = stall;
      end while (busy);
      if (legal) begin
         e.wb   = !store && rd != 5'd0;
         e.rd   = rd;
         e.data = load_result(model_mem[addr[7:2]], f3, addr[1:0]);
         exp_q.push_back(e);
         if (store) begin
            model_mem[addr[7:2]] = merge_store(model_mem[addr[7:2]], f3, addr[1:0], data);
         end
      end
   endtask

   // ==============================
   // Memory slave
   // ==============================
   always @(posedge clk) begin
      if (rst_n) begin
         if (pending && hreadyd) begin
            if (d_write) begin
               for (int b = 0; b < 4; b++) begin
                  if (d_lanes[b]) mem[d_idx][8*b +: 8] = hwdatad[8*b +: 8];
               end
            end
            assert (exp_q.size() != 0) else begin
               errors++;
               $display("ERROR: %0t data phase completed with no transfer expected", $time);
            end
            if (exp_q.size() != 0) begin
               check_value("wb_valid", 32'(exp_q[0].wb), 32'(wb_valid));
               if (exp_q[0].wb) begin
                  check_value("wb_rd", 32'(exp_q[0].rd), 32'(wb_rd));
                  check_value("wb_data", exp_q[0].data, wb_data);
               end
               void'(exp_q.pop_front());
            end
         end else begin
            check_value("wb_valid", 32'd0, 32'(wb_valid));
         end
         check_value("stall", 32'(pending & ~hreadyd), 32'(stall));
         if (hreadyd) begin
            pending = htransd;
            d_write = hwrited;
            d_idx   = haddrd[7:2];
            case (hsized)
               `LSU_HSIZE_BYTE: d_lanes = 4'b0001 << haddrd[1:0];
               `LSU_HSIZE_HALF: d_lanes = 4'b0011 << haddrd[1:0];
               default:         d_lanes = 4'b1111;
            endcase
         end
      end else begin
         pending = 1'b0;
      end
      #1;
      // Wait states only while a data phase is open
      bus_r   = $random(seed);
      hreadyd = pending ? (bus_r[1:0] != 2'b00) : 1'b1;
      hrdatad = (pending && !d_write) ? mem[d_idx] : bus_r;
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles > CYCLE_LIMIT) begin
         errors++;
         $display("ERROR: timeout after %0d cycles, operations did not complete", cycles);
         finish_run();
      end
   end

   // ==============================
   // Stimulus
   // ==============================
   initial begin
      logic [31:0] r;
      logic [31:0] data;
      logic [31:0] addr;
      logic [1:0]  sz;
      logic [2:0]  f3;
      rst_n      = 1'b0;
      inst_valid = 1'b0;
      inst       = 32'd0;
      rs1_value  = 32'd0;
      rs2_value  = 32'd0;
      for (int i = 0; i < 64; i++) begin
         mem[i]       = fill_word(i);
         model_mem[i] = fill_word(i);
      end
      repeat (16) @(posedge clk);
      #1 rst_n = 1'b1;
      @(posedge clk);
      check_value("htransd", 32'd0, 32'(htransd));
      check_value("stall", 32'd0, 32'(stall));
      check_value("wb_valid", 32'd0, 32'(wb_valid));

      // Every size at every legal offset, read back as a word and as itself
      for (int off = 0; off < 4; off++) begin
         for (int s = 0; s < 3; s++) begin
            if (off % (1 << s) == 0) begin
               data = $random(seed);
               apply_op(1'b1, 3'(s), DIR_BASE + 32'(off), 5'd0, data, 1'b0);
               apply_op(1'b0, `LSU_F3_LW, DIR_BASE, 5'd1, 32'd0, 1'b0);
               apply_op(1'b0, 3'(s), DIR_BASE + 32'(off), 5'd2, 32'd0, 1'b0);
               if (s != 2) begin
                  apply_op(1'b0, {1'b1, 2'(s)}, DIR_BASE + 32'(off), 5'd3, 32'd0, 1'b0);
               end
            end
         end
      end

      repeat (N_RANDOM) begin
         r    = $random(seed);
         data = $random(seed);
         if (r[7:6] == 2'd0) begin
            #1 inst_valid = 1'b0;
            @(posedge clk);
         end
         sz   = (r[3:2] == 2'd3) ? 2'd2 : r[3:2];
         f3   = {~r[0] & r[1] & (sz != 2'd2), sz};
         addr = {24'd0, r[15:8]};
         // Kind 0 bad opcode, kind 1 undefined funct3, kind 2 raw offset
         if (r[19:16] == 4'd1) begin
            f3 = r[0] ? {1'b1, r[21:20]} : {r[20], 2'b11};
         end
         if (r[19:16] != 4'd2) begin
            addr = addr & ~((32'd1 << sz) - 32'd1);
         end
         apply_op(r[0], f3, addr, (r[25:22] == 4'd0) ? 5'd0 : r[30:26], data,
                  r[19:16] == 4'd0);
      end

      #1 inst_valid = 1'b0;
      while (exp_q.size() != 0) @(posedge clk);
      repeat (2) @(posedge clk);
      for (int i = 0; i < 64; i++) begin
         check_value("mem", model_mem[i], mem[i]);
      end
      finish_run();
   end

endmodule

// File: files.f
+incdir+.
lsu_pkg.sv
lsu_decode.sv
lsu_store_align.sv
lsu_load_align.sv
lsu_phase_ctrl.sv
lsu_top.sv
lsu_chk.sv
tb_lsu.sv

// File: run.sh
#!/bin/sh
# Builds the load/store unit testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f files.f --top-module tb_lsu -Mdir obj_dir -o sim_lsu
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/sim_lsu +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -qx "SIMULATION PASSED"; then
   exit 0
fi
exit 1
